//--- src/ipod_pkg.sv
package ipod_pkg;

  // ==================================================
  // Keyboard commands, upper-case ASCII
  // ==================================================
  localparam logic [7:0] cmd_play     = 8'h45;  // E
  localparam logic [7:0] cmd_pause    = 8'h44;  // D
  localparam logic [7:0] cmd_forward  = 8'h46;  // F
  localparam logic [7:0] cmd_backward = 8'h42;  // B
  localparam logic [7:0] cmd_restart  = 8'h52;  // R

  // ==================================================
  // Sample and flash word geometry
  // ==================================================
  localparam int sample_w     = 16;
  localparam int flash_data_w = 32;
  localparam int flash_addr_w = 23;

  // Kept small so the wrap point is reachable in simulation
  localparam logic [flash_addr_w-1:0] last_word_addr = 23'h0000ff;

  // Player FSM encoding
  localparam logic [1:0] st_idle      = 2'd0;
  localparam logic [1:0] st_request   = 2'd1;
  localparam logic [1:0] st_wait_data = 2'd2;

  // ==================================================
  // Sample rate divisor
  // ==================================================
  localparam int divisor_w = 16;

  // About 44 kHz from the 50 MHz clock
  localparam logic [divisor_w-1:0] default_divisor = 16'd1136;
  localparam logic [divisor_w-1:0] divisor_step    = 16'd16;
  localparam logic [divisor_w-1:0] min_divisor     = 16'd64;
  localparam logic [divisor_w-1:0] max_divisor     = 16'd4095;

  // Hold-to-repeat interval, 100 ms
  localparam logic [31:0] repeat_cycles = 32'd5_000_000;

  // Seven-segment display
  localparam int num_digits = 6;
  localparam int seg_w      = 7;
  localparam logic [seg_w-1:0] seg_blank = 7'h7f;

endpackage

//--- src/kbd_command_decoder.sv
`timescale 1ns/1ps

module kbd_command_decoder (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic [7:0] kbd_ascii,
  input  logic       kbd_ready,
  output logic       playing,
  output logic       backward,
  output logic       restart
);
  import ipod_pkg::*;

  logic [7:0] cmd_char;

  // Clearing bit 5 folds lower case onto upper case
  assign cmd_char = kbd_ascii & 8'hdf;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      playing  <= 1'b0;
      backward <= 1'b0;
      restart  <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (kbd_ready)
      begin
        case (cmd_char)
          cmd_play:
            playing <= 1'b1;
          cmd_pause:
            playing <= 1'b0;
          cmd_forward:
            backward <= 1'b0;
          cmd_backward:
            backward <= 1'b1;
          // Single-cycle pulse to the player
          cmd_restart:
            restart <= 1'b1;
          default:
          begin
          end
        endcase
      end
    end
  end

endmodule

//--- src/rate_control.sv
`timescale 1ns/1ps

module rate_control (
  input  logic                           CLK_50M,
  input  logic                           reset,
  input  logic                           speed_up,
  input  logic                           speed_down,
  input  logic                           speed_reset,
  output logic [ipod_pkg::divisor_w-1:0] divisor,
  output logic                           sample_tick
);
  import ipod_pkg::*;

  // Button vectors are ordered {speed_reset, speed_down, speed_up}
  logic [2:0]           sync_a;
  logic [2:0]           sync_b;
  logic [2:0]           level_q;
  logic [2:0]           rise;
  logic [2:0]           step_evt;
  logic                 rep_fire;
  logic [31:0]          rep_cnt;
  logic [divisor_w-1:0] tick_cnt;
  logic [divisor_w-1:0] tick_last;

  // ==================================================
  // Button synchronizers and press-and-repeat
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      sync_a  <= '0;
      sync_b  <= '0;
      level_q <= '0;
    end
    else
    begin
      sync_a  <= {speed_reset, speed_down, speed_up};
      sync_b  <= sync_a;
      level_q <= sync_b;
    end
  end

  assign rise     = sync_b & ~level_q;
  assign rep_fire = (rep_cnt == repeat_cycles - 32'd1);
  assign step_evt = rise | (sync_b & {3{rep_fire}});

  // Restarts on every new press and idles when nothing is held
  always_ff @(posedge CLK_50M)
  begin
    if (reset || (rise != 3'b000) || (sync_b == 3'b000) || rep_fire)
      rep_cnt <= '0;
    else
      rep_cnt <= rep_cnt + 32'd1;
  end

  // ==================================================
  // Divisor register
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset || step_evt[2])
      divisor <= default_divisor;
    else if (step_evt[0])
      divisor <= (divisor > max_divisor - divisor_step) ? max_divisor : divisor + divisor_step;
    else if (step_evt[1])
      divisor <= (divisor < min_divisor + divisor_step) ? min_divisor : divisor - divisor_step;
  end

  // Period is latched at each wrap so a change takes effect next period
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      tick_cnt    <= '0;
      tick_last   <= default_divisor - 16'd1;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt == tick_last)
    begin
      tick_cnt    <= '0;
      tick_last   <= divisor - 16'd1;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt + 16'd1;
      sample_tick <= 1'b0;
    end
  end

endmodule

//--- src/flash_player.sv
`timescale 1ns/1ps

module flash_player (
  input  logic                              CLK_50M,
  input  logic                              reset,
  input  logic                              playing,
  input  logic                              backward,
  input  logic                              restart,
  input  logic                              sample_tick,
  output logic                              flash_read,
  output logic [ipod_pkg::flash_addr_w-1:0] flash_address,
  input  logic                              flash_waitrequest,
  input  logic [ipod_pkg::flash_data_w-1:0] flash_readdata,
  input  logic                              flash_readdatavalid,
  output logic [ipod_pkg::sample_w-1:0]     audio_sample,
  output logic                              sample_valid
);
  import ipod_pkg::*;

  logic [1:0]              state;
  logic [flash_addr_w-1:0] word_addr;
  logic                    half_sel;
  logic                    restart_pend;
  logic [flash_addr_w-1:0] next_addr;
  logic                    next_half;

  // Position only moves while idle or on data return, so the address holds
  assign flash_address = word_addr;

  // ==================================================
  // Next playback position
  // ==================================================
  always_comb
  begin
    next_addr = word_addr;
    next_half = ~half_sel;
    if (!backward)
    begin
      // Upper half done, step to the next word
      if (half_sel)
        next_addr = (word_addr == last_word_addr) ? '0 : word_addr + 1'b1;
    end
    else if (!half_sel)
    begin
      next_addr = (word_addr == '0) ? last_word_addr : word_addr - 1'b1;
    end
  end

  // ==================================================
  // Read master FSM
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state        <= st_idle;
      flash_read   <= 1'b0;
      sample_valid <= 1'b0;
      word_addr    <= '0;
      half_sel     <= 1'b0;
      restart_pend <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      restart_pend <= restart_pend | restart;
      case (state)
        st_idle:
        begin
          // Restart held back until no fetch is in flight
          if (restart || restart_pend)
          begin
            word_addr    <= backward ? last_word_addr : '0;
            half_sel     <= backward;
            restart_pend <= 1'b0;
          end
          if (sample_tick && playing)
          begin
            flash_read <= 1'b1;
            state      <= st_request;
          end
        end
        st_request:
        begin
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= st_wait_data;
          end
        end
        st_wait_data:
        begin
          if (flash_readdatavalid)
          begin
            sample_valid <= 1'b1;
            if (!restart_pend && !restart)
            begin
              word_addr <= next_addr;
              half_sel  <= next_half;
            end
            state <= st_idle;
          end
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  // Half select picks the sample out of the returned word
  always_ff @(posedge CLK_50M)
  begin
    if ((state == st_wait_data) && flash_readdatavalid)
      audio_sample <= half_sel ? flash_readdata[flash_data_w-1:sample_w]
                               : flash_readdata[sample_w-1:0];
  end

endmodule

//--- src/seven_seg_display.sv
`timescale 1ns/1ps

module seven_seg_display (
  input  logic                           CLK_50M,
  input  logic                           reset,
  input  logic [ipod_pkg::divisor_w-1:0] divisor,
  output logic [ipod_pkg::seg_w-1:0]     hex0,
  output logic [ipod_pkg::seg_w-1:0]     hex1,
  output logic [ipod_pkg::seg_w-1:0]     hex2,
  output logic [ipod_pkg::seg_w-1:0]     hex3,
  output logic [ipod_pkg::seg_w-1:0]     hex4,
  output logic [ipod_pkg::seg_w-1:0]     hex5
);
  import ipod_pkg::*;

  logic [4*num_digits-1:0] digits;
  logic [seg_w-1:0]        seg_q [num_digits];

  assign digits = {{(4*num_digits-divisor_w){1'b0}}, divisor};

  // Active low, segment a in bit 0
  function automatic logic [seg_w-1:0] hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'ha: return 7'h08;
      4'hb: return 7'h03;
      4'hc: return 7'h46;
      4'hd: return 7'h21;
      4'he: return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    for (int i = 0; i < num_digits; i++)
    begin
      if (reset)
        seg_q[i] <= seg_blank;
      else
        seg_q[i] <= hex_to_seg(digits[4*i +: 4]);
    end
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];
  assign hex4 = seg_q[4];
  assign hex5 = seg_q[5];

endmodule

//--- src/ipod_top.sv
`timescale 1ns/1ps

module ipod_top (
  input  logic                              CLK_50M,
  input  logic                              reset,
  input  logic [7:0]                        kbd_ascii,
  input  logic                              kbd_ready,
  input  logic                              speed_up,
  input  logic                              speed_down,
  input  logic                              speed_reset,
  input  logic                              flash_waitrequest,
  input  logic [ipod_pkg::flash_data_w-1:0] flash_readdata,
  input  logic                              flash_readdatavalid,
  output logic                              flash_read,
  output logic [ipod_pkg::flash_addr_w-1:0] flash_address,
  output logic [ipod_pkg::sample_w-1:0]     audio_sample,
  output logic                              sample_valid,
  output logic [ipod_pkg::seg_w-1:0]        hex0,
  output logic [ipod_pkg::seg_w-1:0]        hex1,
  output logic [ipod_pkg::seg_w-1:0]        hex2,
  output logic [ipod_pkg::seg_w-1:0]        hex3,
  output logic [ipod_pkg::seg_w-1:0]        hex4,
  output logic [ipod_pkg::seg_w-1:0]        hex5
);
  import ipod_pkg::*;

  logic                 playing;
  logic                 backward;
  logic                 restart;
  logic                 sample_tick;
  logic [divisor_w-1:0] divisor;

  // Keyboard commands
  kbd_command_decoder u_kbd_command_decoder (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .kbd_ascii (kbd_ascii),
    .kbd_ready (kbd_ready),
    .playing   (playing),
    .backward  (backward),
    .restart   (restart)
  );

  // Speed buttons and sample pacing
  rate_control u_rate_control (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .divisor     (divisor),
    .sample_tick (sample_tick)
  );

  flash_player u_flash_player (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .playing             (playing),
    .backward            (backward),
    .restart             (restart),
    .sample_tick         (sample_tick),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid)
  );

  seven_seg_display u_seven_seg_display (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .divisor (divisor),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

//--- tests/tb_flash_model.sv
`timescale 1ns/1ps

module tb_flash_model (
  input  logic                              CLK_50M,
  input  logic                              reset,
  input  logic                              read,
  input  logic [ipod_pkg::flash_addr_w-1:0] address,
  output logic                              waitrequest,
  output logic [ipod_pkg::flash_data_w-1:0] readdata,
  output logic                              readdatavalid
);
  import ipod_pkg::*;

  logic [1:0]              wait_cnt;
  logic [1:0]              lat_cnt;
  logic [flash_addr_w-1:0] addr_q;

  // Two stalled cycles per read, then the request is accepted
  assign waitrequest = read && (wait_cnt != 2'd2);

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      wait_cnt      <= '0;
      lat_cnt       <= '0;
      addr_q        <= '0;
      readdata      <= '0;
      readdatavalid <= 1'b0;
    end
    else
    begin
      readdatavalid <= 1'b0;
      if (read && waitrequest)
        wait_cnt <= wait_cnt + 2'd1;
      else if (read)
      begin
        wait_cnt <= '0;
        addr_q   <= address;
        lat_cnt  <= 2'd3;
      end
      // Data returns 3 cycles after acceptance
      if (lat_cnt != 2'd0)
      begin
        lat_cnt <= lat_cnt - 2'd1;
        if (lat_cnt == 2'd1)
        begin
          readdatavalid <= 1'b1;
          readdata      <= {addr_q[15:0] ^ 16'h5a00, addr_q[15:0]};
        end
      end
    end
  end

endmodule

//--- tests/tb_ipod_top.sv
`timescale 1ns/1ps

module tb_ipod_top;
  import ipod_pkg::*;

  // Active-low patterns for hex digits 0 to F with segment a in bit 0
  localparam logic [6:0] seg_table [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };
  localparam int sample_timeout = 2 * 4096 + 64;

  logic                    CLK_50M;
  logic                    reset;
  logic [7:0]              kbd_ascii;
  logic                    kbd_ready;
  logic                    speed_up;
  logic                    speed_down;
  logic                    speed_reset;
  logic                    flash_waitrequest;
  logic [flash_data_w-1:0] flash_readdata;
  logic                    flash_readdatavalid;
  logic                    flash_read;
  logic [flash_addr_w-1:0] flash_address;
  logic [sample_w-1:0]     audio_sample;
  logic                    sample_valid;
  logic [seg_w-1:0]        hex0, hex1, hex2, hex3, hex4, hex5;
  logic [6*seg_w-1:0]      hex_bus;

  // Reference model of the playback position and the divisor
  logic [flash_addr_w-1:0] exp_addr;
  logic                    exp_half;
  logic                    exp_back;
  int                      exp_div;
  integer                  seed;

  assign hex_bus = {hex5, hex4, hex3, hex2, hex1, hex0};

  ipod_top u_dut (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .kbd_ascii           (kbd_ascii),
    .kbd_ready           (kbd_ready),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  tb_flash_model u_flash (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .read          (flash_read),
    .address       (flash_address),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got == expected)
    else
      report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, expected));
  endtask

  // Outputs are read and inputs driven 2 ns after the edge
  task automatic next_cycle();
    @(posedge CLK_50M);
    #2;
  endtask

  function automatic logic [15:0] expected_sample(input logic [flash_addr_w-1:0] addr,
                                                  input logic half);
    if (half)
      return addr[15:0] ^ 16'h5a00;
    else
      return addr[15:0];
  endfunction

  task automatic advance_position();
    if (!exp_back && exp_half)
      exp_addr = (exp_addr == last_word_addr) ? '0 : exp_addr + 23'd1;
    else if (exp_back && !exp_half)
      exp_addr = (exp_addr == '0) ? last_word_addr : exp_addr - 23'd1;
    exp_half = ~exp_half;
  endtask

  task automatic send_key(input logic [7:0] ch);
    kbd_ascii = ch;
    kbd_ready = 1'b1;
    next_cycle();
    kbd_ready = 1'b0;
    next_cycle();
  endtask

  task automatic check_display();
    logic [23:0] digits;
    digits = {8'h00, exp_div[15:0]};
    for (int i = 0; i < num_digits; i++)
      check_value($sformatf("hex%0d", i), hex_bus[seg_w*i +: seg_w], seg_table[digits[4*i +: 4]]);
  endtask

  task automatic expect_quiet(input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      next_cycle();
      check_value("sample_valid", sample_valid, 0);
      check_value("flash_read", flash_read, 0);
    end
  endtask

  // First spacing is skipped, since playback resumes at an arbitrary tick phase
  task automatic collect_samples(input int count);
    int gap;
    for (int i = 0; i < count; i++)
    begin
      next_cycle();
      gap = 1;
      while (sample_valid !== 1'b1)
      begin
        if (flash_read)
          check_value("flash_address", flash_address, exp_addr);
        if (gap > sample_timeout)
          report_failure("no sample_valid pulse arrived within the timeout");
        else
        begin
          next_cycle();
          gap++;
        end
      end
      if (i > 0)
        check_value("sample_valid spacing", gap, exp_div);
      check_value("audio_sample", audio_sample, expected_sample(exp_addr, exp_half));
      advance_position();
    end
  endtask

  // Buttons ordered {speed_reset, speed_down, speed_up}
  task automatic press_button(input logic [2:0] buttons);
    {speed_reset, speed_down, speed_up} = buttons;
    repeat (4) next_cycle();
    {speed_reset, speed_down, speed_up} = 3'b000;
    repeat (4) next_cycle();
    if (buttons[2])
      exp_div = default_divisor;
    else if (buttons[0])
      exp_div = (exp_div + divisor_step > max_divisor) ? max_divisor : exp_div + divisor_step;
    else
      exp_div = (exp_div < min_divisor + divisor_step) ? min_divisor : exp_div - divisor_step;
    check_display();
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic test_idle_after_reset();
    repeat (2) next_cycle();
    check_display();
    expect_quiet(2000);
  endtask

  task automatic test_forward_play();
    send_key(cmd_play);
    collect_samples(4 + ($random(seed) & 7));
  endtask

  task automatic test_pause_resume();
    send_key(cmd_pause);
    expect_quiet(3 * exp_div);
    send_key(cmd_play);
    collect_samples(4 + ($random(seed) & 7));
    send_key(cmd_pause);
    expect_quiet(3 * exp_div);
    // Lower-case e
    send_key(cmd_play | 8'h20);
    collect_samples(4 + ($random(seed) & 7));
  endtask

  task automatic test_backward_restart_wrap();
    send_key(cmd_pause);
    send_key(cmd_backward);
    send_key(cmd_restart);
    exp_back = 1'b1;
    exp_addr = last_word_addr;
    exp_half = 1'b1;
    send_key(cmd_play);
    collect_samples(4 + ($random(seed) & 7));
    send_key(cmd_pause);
    send_key(cmd_forward);
    exp_back = 1'b0;
    send_key(cmd_play);
    // Enough samples to run past last_word_addr into address 0
    collect_samples(2 * int'(last_word_addr - exp_addr) + 4);
  endtask

  task automatic test_speed_buttons();
    send_key(cmd_pause);
    press_button(3'b001);
    send_key(cmd_play);
    collect_samples(4);
    send_key(cmd_pause);
    press_button(3'b010);
    press_button(3'b010);
    press_button(3'b100);
    repeat (70) press_button(3'b010);
    send_key(cmd_play);
    collect_samples(6);
  endtask

  initial
  begin
    seed        = 32'h86c9_7fb8;
    reset       = 1'b1;
    kbd_ascii   = 8'h00;
    kbd_ready   = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    exp_addr    = '0;
    exp_half    = 1'b0;
    exp_back    = 1'b0;
    exp_div     = default_divisor;
    repeat (2) @(posedge CLK_50M);
    #2;
    reset = 1'b0;

    test_idle_after_reset();
    test_forward_play();
    test_pause_resume();
    test_backward_restart_wrap();
    test_speed_buttons();

    $display("all tests passed");
    $finish;
  end

endmodule

//--- build.f
src/ipod_pkg.sv
src/kbd_command_decoder.sv
src/rate_control.sv
src/flash_player.sv
src/seven_seg_display.sv
src/ipod_top.sv
tests/tb_flash_model.sv
tests/tb_ipod_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ipod_top --Mdir obj_dir -o vsim -f build.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/vsim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi
exit 0
